//--- flist.f
+incdir+source
source/pi_time_pkg.sv
source/pi_ctl_pkg.sv
source/edge_timebase.sv
source/delay_gen.sv
source/edge_fifo.sv
source/edge_scheduler.sv
source/phase_interpolator.sv
verif/phase_interpolator_props.sv
verif/tb_phase_interpolator.sv

//--- verif/tb_phase_interpolator.sv
`timescale 1ns/1ps
`include "pi_cfg.svh"

module tb_phase_interpolator;
    import pi_time_pkg::*;
    import pi_ctl_pkg::*;

    localparam int reset_cycles = 4;
    localparam int phase_cycles = 300;
    localparam int burst_cycles = 60;
    localparam int drain_cycles = 100;
    localparam int total_cycles = reset_cycles + 2 * phase_cycles + burst_cycles + drain_cycles;
    localparam int cycle_limit  = total_cycles * 3 / 2;

    logic        emu_clk;
    logic        reset;
    step_t       emu_dt;
    logic        clk_in;
    logic        ctl_valid;
    code_t       ctl;
    jit_amp_t    jitter_amp;
    logic        clk_out_slice;
    step_t       dt_req;
    logic        overflow;

    // reference model, mirrors the registered state of the DUT
    abs_time_t   m_now;
    logic        m_clk_prev;
    logic        m_ev_valid;
    in_edge_t    m_ev;
    code_t       m_code;
    logic [15:0] m_lfsr;
    abs_time_t   m_last_due;
    pend_edge_t  m_queue[$];
    logic        m_out;
    logic        m_ovf;
    logic        m_popped;

    integer      seed;
    int          errors;
    int          checks;
    int          cycles;

    phase_interpolator phase_interpolator_i (.*);

    initial begin
        emu_clk = 1'b0;
        forever #5 emu_clk = ~emu_clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge emu_clk);
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("timeout: run did not finish within %0d cycles", cycle_limit);
                $display("checks %0d, errors %0d", checks, errors + 1);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    end

    task automatic report_mismatch(input string what, input longint got, input longint exp);
        errors++;
        $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    endtask

    // largest step that stops on the head due time
    function automatic step_t model_dt_req();
        abs_time_t wait_ticks;
        if (m_queue.size() == 0) return '1;
        if (m_queue[0].due <= m_now) return step_t'(1);
        wait_ticks = m_queue[0].due - m_now;
        if (wait_ticks > 32'h0000_ffff) return '1;
        return step_t'(wait_ticks);
    endfunction

    task automatic model_step();
        abs_time_t  dly;
        pend_edge_t fresh;
        logic       was_full;
        logic       pop;
        dly = `PI_BASE_TICKS + abs_time_t'(m_code) * `PI_STEP_TICKS
            + abs_time_t'(m_lfsr[`PI_JIT_W-1:0] & jitter_amp);
        was_full = (m_queue.size() == `PI_QUEUE_DEPTH);
        pop = (m_queue.size() != 0) && (m_queue[0].due <= m_now);
        if (pop) begin
            // late only while a backlog of equal due times drains
            checks++;
            assert (m_queue[0].due == m_now || m_popped) else begin
                errors++;
                $display("edge skipped at %0t: due time passed before the step reached it", $time);
            end
            m_out = m_queue[0].level;
            void'(m_queue.pop_front());
        end
        m_popped = pop;
        if (m_ev_valid) begin
            fresh.level = m_ev.level;
            fresh.due   = m_ev.stamp + dly;
            if (fresh.due < m_last_due) fresh.due = m_last_due;
            if (was_full) begin
                m_ovf = 1'b1;
            end else begin
                m_queue.push_back(fresh);
                m_last_due = fresh.due;
            end
            m_lfsr = (m_lfsr >> 1) ^ (m_lfsr[0] ? 16'hb400 : 16'h0000);
        end
        if (ctl_valid) m_code = ctl;
        m_ev_valid = (clk_in != m_clk_prev);
        m_ev.level = clk_in;
        m_ev.stamp = m_now + abs_time_t'(emu_dt);
        m_now      = m_ev.stamp;
        m_clk_prev = clk_in;
    endtask

    task automatic compare_outputs();
        checks++;
        assert (clk_out_slice === m_out) else report_mismatch("clk_out_slice", clk_out_slice, m_out);
        assert (overflow === m_ovf) else report_mismatch("overflow", overflow, m_ovf);
        assert (dt_req === model_dt_req()) else report_mismatch("dt_req", dt_req, model_dt_req());
        assert (int'(phase_interpolator_i.edge_scheduler_i.edge_fifo_i.count) == m_queue.size())
            else report_mismatch("pending edges",
                phase_interpolator_i.edge_scheduler_i.edge_fifo_i.count, m_queue.size());
    endtask

    // odds 0 keeps clk_in still, fast forces single tick steps
    task automatic drive_step(input int odds, input logic fast);
        step_t limit;
        limit = dt_req;
        // an edge detected last step is not queued yet, stay below its earliest due
        if (m_ev_valid && limit > `PI_BASE_TICKS) limit = `PI_BASE_TICKS;
        emu_dt = fast ? step_t'(1) : step_t'(1 + ({$random(seed)} % limit));
        if (odds != 0 && ({$random(seed)} % odds) == 0) clk_in = ~clk_in;
        ctl_valid = (({$random(seed)} % 16) == 0);
        ctl = code_t'($random(seed));
    endtask

    task automatic run_phase(input int n, input jit_amp_t amp, input int odds, input logic fast);
        for (int i = 0; i < n; i++) begin
            @(posedge emu_clk);
            model_step();
            #1;
            jitter_amp = amp;
            drive_step(odds, fast);
            @(negedge emu_clk);
            compare_outputs();
        end
    endtask

    initial begin
        seed = 32'hf270156c;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        emu_dt = step_t'(1);
        clk_in = 1'b0;
        ctl_valid = 1'b0;
        ctl = '0;
        jitter_amp = '0;
        m_now = '0;
        m_clk_prev = 1'b0;
        m_ev_valid = 1'b0;
        m_ev = '0;
        m_code = '0;
        m_lfsr = `PI_JITTER_SEED;
        m_last_due = '0;
        m_out = 1'b0;
        m_ovf = 1'b0;
        m_popped = 1'b0;
        repeat (reset_cycles) @(posedge emu_clk);
        #1;
        reset = 1'b0;
        @(negedge emu_clk);
        compare_outputs();
        run_phase(phase_cycles, 7'h00, 8, 1'b0);
        run_phase(phase_cycles, 7'h7f, 6, 1'b0);
        run_phase(burst_cycles, 7'h35, 1, 1'b1);
        checks++;
        assert (m_ovf && overflow) else begin
            errors++;
            $display("edge burst did not fill the queue and raise overflow");
        end
        run_phase(drain_cycles, 7'h35, 0, 1'b0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verif/phase_interpolator_props.sv
`timescale 1ns/1ps

module phase_interpolator_props (
    input logic               emu_clk,
    input logic               reset,
    input logic               push,
    input logic               pop,
    input logic               fifo_full,
    input logic               clk_out_slice,
    input logic               overflow,
    input pi_time_pkg::step_t dt_req
);
    // edges accepted into the queue and not popped yet
    int unsigned held;

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            held <= 0;
        end else begin
            held <= held + ((push && !fifo_full) ? 1 : 0) - (pop ? 1 : 0);
        end
    end

    // output level moves only when the head edge leaves the queue
    out_on_pop: assert property (@(posedge emu_clk) disable iff (reset)
        (clk_out_slice != $past(clk_out_slice)) |-> $past(pop))
        else $error("clk_out_slice changed without a pop");

    step_nonzero: assert property (@(posedge emu_clk) disable iff (reset) dt_req != '0)
        else $error("dt_req is zero");

    pop_not_empty: assert property (@(posedge emu_clk) disable iff (reset)
        pop |-> held != 0)
        else $error("pop requested while the queue is empty");

    // sticky flag
    overflow_held: assert property (@(posedge emu_clk) disable iff (reset)
        $past(overflow) |-> overflow)
        else $error("overflow fell after being set");

endmodule

bind edge_scheduler phase_interpolator_props phase_interpolator_props_i (
    .emu_clk       (emu_clk),
    .reset         (reset),
    .push          (in_edge_valid),
    .pop           (pop),
    .fifo_full     (fifo_full),
    .clk_out_slice (clk_out_slice),
    .overflow      (overflow),
    .dt_req        (dt_req)
);

//--- source/phase_interpolator.sv
`timescale 1ns/1ps

module phase_interpolator (
    input  logic                 emu_clk,
    input  logic                 reset,
    input  pi_time_pkg::step_t   emu_dt,
    input  logic                 clk_in,
    input  logic                 ctl_valid,
    input  pi_ctl_pkg::code_t    ctl,
    input  pi_ctl_pkg::jit_amp_t jitter_amp,
    output logic                 clk_out_slice,
    output pi_time_pkg::step_t   dt_req,
    output logic                 overflow
);
    import pi_time_pkg::*;
    import pi_ctl_pkg::*;

    abs_time_t now;
    abs_time_t delay;
    in_edge_t  in_edge;
    logic      in_edge_valid;
    logic      take;

    // simulated time and input edge stamps
    edge_timebase edge_timebase_i (
        .emu_clk       (emu_clk),
        .reset         (reset),
        .emu_dt        (emu_dt),
        .clk_in        (clk_in),
        .now           (now),
        .in_edge_valid (in_edge_valid),
        .in_edge       (in_edge)
    );

    delay_gen delay_gen_i (
        .emu_clk    (emu_clk),
        .reset      (reset),
        .ctl_valid  (ctl_valid),
        .ctl        (ctl),
        .jitter_amp (jitter_amp),
        .take       (take),
        .delay      (delay)
    );

    // pending edges, output level and step request
    edge_scheduler edge_scheduler_i (
        .emu_clk       (emu_clk),
        .reset         (reset),
        .now           (now),
        .in_edge_valid (in_edge_valid),
        .in_edge       (in_edge),
        .delay         (delay),
        .take          (take),
        .clk_out_slice (clk_out_slice),
        .dt_req        (dt_req),
        .overflow      (overflow)
    );

endmodule

//--- source/edge_scheduler.sv
`timescale 1ns/1ps
`include "pi_cfg.svh"

module edge_scheduler (
    input  logic                   emu_clk,
    input  logic                   reset,
    input  pi_time_pkg::abs_time_t now,
    input  logic                   in_edge_valid,
    input  pi_ctl_pkg::in_edge_t   in_edge,
    input  pi_time_pkg::abs_time_t delay,
    output logic                   take,
    output logic                   clk_out_slice,
    output pi_time_pkg::step_t     dt_req,
    output logic                   overflow
);
    import pi_time_pkg::*;
    import pi_ctl_pkg::*;

    // largest step the time manager may take with nothing pending
    localparam step_t dt_req_max = '1;

    abs_time_t  last_due;
    abs_time_t  due_raw;
    abs_time_t  due;
    abs_time_t  head_wait;
    pend_edge_t new_edge;
    pend_edge_t head;
    logic       fifo_empty;
    logic       fifo_full;
    logic       pop;

    // never schedule ahead of the previously accepted edge
    assign due_raw        = in_edge.stamp + delay;
    assign due            = (due_raw < last_due) ? last_due : due_raw;
    assign new_edge.level = in_edge.level;
    assign new_edge.due   = due;

    // every incoming edge consumes one jitter value
    assign take = in_edge_valid;

    assign pop = !fifo_empty && (head.due <= now);

    edge_fifo #(
        .payload_t (pend_edge_t),
        .depth     (`PI_QUEUE_DEPTH)
    ) edge_fifo_i (
        .emu_clk   (emu_clk),
        .reset     (reset),
        .push      (in_edge_valid),
        .push_data (new_edge),
        .pop       (pop),
        .head      (head),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            last_due      <= '0;
            clk_out_slice <= 1'b0;
            overflow      <= 1'b0;
        end else begin
            if (in_edge_valid && !fifo_full) begin
                last_due <= due;
            end
            if (pop) begin
                clk_out_slice <= head.level;
            end
            // sticky, a dropped edge means the output is wrong from here on
            if (in_edge_valid && fifo_full) begin
                overflow <= 1'b1;
            end
        end
    end

    // step request stops exactly on the head due time
    assign head_wait = head.due - now;

    always_comb begin
        if (fifo_empty) begin
            dt_req = dt_req_max;
        end else if (head.due <= now) begin
            dt_req = step_t'(1);
        end else if (head_wait > abs_time_t'(dt_req_max)) begin
            dt_req = dt_req_max;
        end else begin
            dt_req = step_t'(head_wait);
        end
    end

endmodule

//--- source/edge_fifo.sv
`timescale 1ns/1ps
`include "pi_cfg.svh"

module edge_fifo #(
    parameter type payload_t = pi_ctl_pkg::pend_edge_t,
    parameter int  depth     = `PI_QUEUE_DEPTH
) (
    input  logic     emu_clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               do_push;
    logic               do_pop;

    // a push into a full buffer is dropped, a pop on empty is ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));
    assign head  = mem[rd_ptr];

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge emu_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- source/delay_gen.sv
`timescale 1ns/1ps
`include "pi_cfg.svh"

module delay_gen #(
    parameter logic [15:0] jitter_seed = `PI_JITTER_SEED
) (
    input  logic                   emu_clk,
    input  logic                   reset,
    input  logic                   ctl_valid,
    input  pi_ctl_pkg::code_t      ctl,
    input  pi_ctl_pkg::jit_amp_t   jitter_amp,
    input  logic                   take,
    output pi_time_pkg::abs_time_t delay
);
    import pi_time_pkg::*;
    import pi_ctl_pkg::*;

    // taps of x^16+x^14+x^13+x^11+1 for a right shifting Galois LFSR
    localparam logic [15:0] lfsr_taps = 16'hb400;

    code_t       code_q;
    logic [15:0] lfsr;
    jit_amp_t    jitter;

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            code_q <= '0;
        end else if (ctl_valid) begin
            code_q <= ctl;
        end
    end

    // one step per consumed edge so each edge sees its own jitter
    always_ff @(posedge emu_clk) begin
        if (reset) begin
            lfsr <= jitter_seed;
        end else if (take) begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? lfsr_taps : 16'h0000);
        end
    end

    assign jitter = lfsr[`PI_JIT_W-1:0] & jitter_amp;

    // base + code * step + masked jitter
    assign delay = abs_time_t'(`PI_BASE_TICKS)
                 + abs_time_t'(code_q) * abs_time_t'(`PI_STEP_TICKS)
                 + abs_time_t'(jitter);

endmodule

//--- source/edge_timebase.sv
`timescale 1ns/1ps

module edge_timebase (
    input  logic                  emu_clk,
    input  logic                  reset,
    input  pi_time_pkg::step_t    emu_dt,
    input  logic                  clk_in,
    output pi_time_pkg::abs_time_t now,
    output logic                  in_edge_valid,
    output pi_ctl_pkg::in_edge_t  in_edge
);
    import pi_time_pkg::*;
    import pi_ctl_pkg::*;

    // level of clk_in seen at the end of the previous step
    logic      clk_prev;
    abs_time_t step_end;

    // time reached once the current step is taken
    assign step_end = now + abs_time_t'(emu_dt);

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            now           <= '0;
            clk_prev      <= 1'b0;
            in_edge_valid <= 1'b0;
        end else begin
            now           <= step_end;
            clk_prev      <= clk_in;
            in_edge_valid <= (clk_in != clk_prev);
        end
    end

    // edge record, only meaningful while in_edge_valid is high
    always_ff @(posedge emu_clk) begin
        in_edge.level <= clk_in;
        in_edge.stamp <= step_end;
    end

endmodule

//--- source/pi_ctl_pkg.sv
`include "pi_cfg.svh"

package pi_ctl_pkg;

    // delay code as given by the CDR loop
    typedef logic [`PI_CODE_W-1:0] code_t;

    // mask applied to the LFSR jitter bits
    typedef logic [`PI_JIT_W-1:0] jit_amp_t;

    // input clock transition, stamped at the end of its step
    typedef struct packed {
        logic                   level;
        pi_time_pkg::abs_time_t stamp;
    } in_edge_t;

    // output transition waiting for its due time
    typedef struct packed {
        logic                   level;
        pi_time_pkg::abs_time_t due;
    } pend_edge_t;

endpackage

//--- source/pi_time_pkg.sv
`include "pi_cfg.svh"

package pi_time_pkg;

    // simulated time since reset, in ticks
    typedef logic [`PI_TIME_W-1:0] abs_time_t;

    // size of one emulation step, in ticks
    typedef logic [`PI_DT_W-1:0] step_t;

endpackage

//--- source/pi_cfg.svh
`ifndef PI_CFG_SVH
`define PI_CFG_SVH

// width of absolute simulated time in ticks
`define PI_TIME_W 32

// width of one emulation step
`define PI_DT_W 16

// delay code and jitter mask widths
`define PI_CODE_W 9
`define PI_JIT_W 7

// ticks added per unit of the delay code
`define PI_STEP_TICKS 4

// intrinsic delay of the interpolator with code 0
`define PI_BASE_TICKS 20

// pending output edges that can be in flight
`define PI_QUEUE_DEPTH 8

// start value of the jitter LFSR
`define PI_JITTER_SEED 16'hb55c

`endif
